//--- hdl/zx_pkg.sv
// Shared widths and codes for the memory and port core; the enum order fixes the machine encoding
package zx_pkg;

	// ======================================================================
	// Machine models
	// ======================================================================

	// Two-bit machine code, sampled while reset is high
	typedef enum logic [1:0] {
		machine_zx128 = 2'd0,
		machine_p1024 = 2'd1,
		machine_zx48  = 2'd2,
		machine_plus3 = 2'd3
	} machine_t;

	// ======================================================================
	// Bus and datapath widths
	// ======================================================================

	localparam int addr_w     = 16;
	localparam int ram_addr_w = 25;
	localparam int data_w     = 8;
	localparam int psg_w      = 12;
	localparam int audio_w    = 16;

	// ======================================================================
	// Memory layout
	// ======================================================================

	// Top code of the ROM area inside the flat RAM space
	localparam logic [2:0] rom_region = 3'b101;

	// Fixed banks seen in slots 1 and 2
	localparam logic [2:0] bank_screen0 = 3'd5;
	localparam logic [2:0] bank_fixed2  = 3'd2;

	// ======================================================================
	// I/O ports, full 16-bit numbers as used by software
	// ======================================================================

	localparam logic [addr_w-1:0] port_fe   = 16'h00fe;
	localparam logic [addr_w-1:0] port_7ffd = 16'h7ffd;
	localparam logic [addr_w-1:0] port_1ffd = 16'h1ffd;
	localparam logic [addr_w-1:0] port_eff7 = 16'heff7;

endpackage

//--- hdl/paging_if.sv
// Paging state bundle; page_regs is the only driver and every field is valid from reset on
`timescale 1ns/1ps

interface paging_if;
	import zx_pkg::*;

	// Raw 128K and +3 paging bytes
	logic [data_w-1:0] reg_7ffd;
	logic [data_w-1:0] reg_1ffd;

	// Pentagon 1024 extra bank bits
	logic [2:0]        page_ext;

	// Machine model latched at reset
	machine_t          machine;

	modport src (
		output reg_7ffd, reg_1ffd, page_ext, machine
	);

	modport dst (
		input reg_7ffd, reg_1ffd, page_ext, machine
	);

endinterface

//--- hdl/io_port_unit.sv
// Four-phase I/O write slave; bus_addr and bus_data must stay stable while io_req is high
`timescale 1ns/1ps

module io_port_unit (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [zx_pkg::addr_w-1:0]   bus_addr,
	input  logic [zx_pkg::data_w-1:0]   bus_data,
	input  logic                        io_req,
	output logic                        io_ack,
	output logic                        wr_stb,
	output logic [zx_pkg::addr_w-1:0]   wr_addr,
	output logic [zx_pkg::data_w-1:0]   wr_data,
	output logic [2:0]                  border,
	output logic                        ear,
	output logic                        mic
);

	logic req_new;
	logic sel_fe;

	// New transaction when a request is seen with no ack pending
	assign req_new = io_req & ~io_ack;

	// ULA port, any even address
	assign sel_fe = ~wr_addr[0];

	// ======================================================================
	// Handshake
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_ack <= 1'b0;
			wr_stb <= 1'b0;
		end else begin
			wr_stb <= req_new;
			if (req_new) begin
				io_ack <= 1'b1;
			end else if (!io_req) begin
				io_ack <= 1'b0;
			end
		end
	end

	// Address and data held for the strobe cycle
	always_ff @(posedge clk_sys) begin
		if (req_new) begin
			wr_addr <= bus_addr;
			wr_data <= bus_data;
		end
	end

	// ======================================================================
	// Port #FE register
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (wr_stb && sel_fe) begin
			border <= wr_data[2:0];
			// ear on bit 4, mic on bit 3
			ear    <= wr_data[4];
			mic    <= wr_data[3];
		end
	end

endmodule

//--- hdl/page_regs.sv
// 7FFD, 1FFD and EFF7 paging registers; machine input is sampled only while reset is high
`timescale 1ns/1ps

module page_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_pkg::machine_t          machine,
	input  logic                      wr_stb,
	input  logic [zx_pkg::addr_w-1:0] wr_addr,
	input  logic [zx_pkg::data_w-1:0] wr_data,
	paging_if.src                     pg
);
	import zx_pkg::*;

	machine_t          machine_q;
	logic [data_w-1:0] reg_7ffd;
	logic [data_w-1:0] reg_1ffd;
	logic [data_w-1:0] reg_eff7;
	logic [2:0]        page_ext;

	logic is_zx48;
	logic is_plus3;
	logic is_p1024;
	logic page_lock;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;

	assign is_zx48  = (machine_q == machine_zx48);
	assign is_plus3 = (machine_q == machine_plus3);
	assign is_p1024 = (machine_q == machine_p1024);

	// Bit 5 of 7FFD locks paging; on Pentagon 1024 only in 128K-compatible mode
	assign page_lock = is_zx48 |
		(~is_p1024 & reg_7ffd[5]) |
		(is_p1024 & reg_eff7[2] & reg_7ffd[5]);

	// ======================================================================
	// Partial port decode
	// ======================================================================

	assign sel_7ffd = ~wr_addr[15] & ~wr_addr[1] & (wr_addr[14] | ~is_plus3);
	assign sel_1ffd = is_plus3 & ~wr_addr[1] & wr_addr[12] &
		~wr_addr[13] & ~wr_addr[14] & ~wr_addr[15];
	assign sel_eff7 = is_p1024 & wr_addr[15] & wr_addr[14] & wr_addr[13] &
		~wr_addr[12] & ~wr_addr[3];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine_q <= machine;
			reg_7ffd  <= '0;
			reg_1ffd  <= '0;
			reg_eff7  <= '0;
			page_ext  <= 3'd0;
		end else if (wr_stb) begin
			if (sel_7ffd && !page_lock) begin
				reg_7ffd <= wr_data;
				// Extension bits come from the top of the 7FFD byte
				if (is_p1024 && !reg_eff7[2]) begin
					page_ext <= {wr_data[5], wr_data[7:6]};
				end
			end else if (sel_1ffd && !page_lock) begin
				reg_1ffd <= wr_data;
			end
			if (sel_eff7) begin
				reg_eff7 <= wr_data;
			end
		end
	end

	assign pg.reg_7ffd = reg_7ffd;
	assign pg.reg_1ffd = reg_1ffd;
	assign pg.page_ext = page_ext;
	assign pg.machine  = machine_q;

endmodule

//--- hdl/ram_mapper.sv
// Combinational CPU-to-flat-RAM map; covers ROM, 128K, +3 and Pentagon banks, no MMC overlays
`timescale 1ns/1ps

module ram_mapper (
	input  logic [zx_pkg::addr_w-1:0]     bus_addr,
	paging_if.dst                         pg,
	output logic [zx_pkg::ram_addr_w-1:0] ram_addr,
	output logic                          ram_we_ok
);
	import zx_pkg::*;

	logic [1:0]  slot;
	logic [13:0] offset;
	logic        special;
	logic        zx48;
	logic [3:0]  rom_page;
	logic [1:0]  cfg;
	logic        cfg_any;
	logic [2:0]  spec_bank;
	logic [5:0]  bank;

	assign slot    = bus_addr[15:14];
	assign offset  = bus_addr[13:0];
	assign special = pg.reg_1ffd[0];
	assign zx48    = (pg.machine == machine_zx48);
	assign cfg     = pg.reg_1ffd[2:1];
	assign cfg_any = |cfg;

	// +3 picks among four ROMs, the others between 48K and 128K ROM
	assign rom_page = (pg.machine == machine_plus3) ?
		{2'b10, pg.reg_1ffd[2], pg.reg_7ffd[4]} :
		{zx48, 2'b11, zx48 | pg.reg_7ffd[4]};

	// Special configs 0,1,2,3 / 4,5,6,7 / 4,5,6,3 / 4,7,6,3
	always_comb begin
		case (slot)
			2'd0:    spec_bank = {cfg_any, 2'b00};
			2'd1:    spec_bank = {cfg_any, &cfg, 1'b1};
			2'd2:    spec_bank = {cfg_any, 2'b10};
			default: spec_bank = {~cfg[1] & cfg[0], 2'b11};
		endcase
	end

	always_comb begin
		if (special) begin
			bank = {3'b000, spec_bank};
		end else begin
			case (slot)
				2'd1:    bank = {3'b000, bank_screen0};
				2'd2:    bank = {3'b000, bank_fixed2};
				default: bank = {pg.page_ext, pg.reg_7ffd[2:0]};
			endcase
		end

		if (!special && slot == 2'd0) begin
			ram_addr = {4'b0000, rom_region, rom_page, offset};
		end else begin
			ram_addr = {5'b00000, bank, offset};
		end
	end

	assign ram_we_ok = special | (slot != 2'd0);

endmodule

//--- hdl/audio_mixer.sv
// Beeper plus PSG mixer with soft-knee compressor; two-cycle latency, sums wrap at 16 bits
`timescale 1ns/1ps

module audio_mixer #(
	parameter int comp_factor = 4,
	parameter int comp_gain   = 2
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [zx_pkg::psg_w-1:0]   psg_l,
	input  logic [zx_pkg::psg_w-1:0]   psg_r,
	input  logic                       ear,
	input  logic                       mic,
	output logic [zx_pkg::audio_w-1:0] audio_l,
	output logic [zx_pkg::audio_w-1:0] audio_r
);
	import zx_pkg::*;

	// Knee chosen so full scale lands near 16-bit full scale
	localparam int knee     = ((32767 * (comp_factor - 1)) / (comp_factor * comp_gain - 1)) + 1;
	localparam int knee_out = knee * comp_gain;

	logic [audio_w-1:0] beep;
	logic [audio_w-1:0] pre_l;
	logic [audio_w-1:0] pre_r;

	// Sign-magnitude compress of a signed sample
	function automatic logic [audio_w-1:0] compress(input logic [audio_w-1:0] x);
		logic [audio_w-1:0] mag;
		logic [audio_w-1:0] shaped;
		mag = x[audio_w-1] ? (~x + 1'b1) : x;
		if (mag < audio_w'(knee)) begin
			shaped = mag * audio_w'(comp_gain);
		end else begin
			shaped = ((mag - audio_w'(knee)) / audio_w'(comp_factor)) + audio_w'(knee_out);
		end
		return x[audio_w-1] ? (~shaped + 1'b1) : shaped;
	endfunction

	// ear at bit 12, mic at bit 11
	assign beep = (audio_w'(ear) << 12) + (audio_w'(mic) << 11);

	// ======================================================================
	// Stage 1 sum, stage 2 compress
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_l   <= '0;
			pre_r   <= '0;
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			pre_l   <= {psg_l, {(audio_w - psg_w){1'b0}}} + beep;
			pre_r   <= {psg_r, {(audio_w - psg_w){1'b0}}} + beep;
			audio_l <= compress(pre_l);
			audio_r <= compress(pre_r);
		end
	end

endmodule

//--- hdl/zx_mem_core.sv
// Top of the paging, port and audio core; machine model takes effect only through a reset
`timescale 1ns/1ps

module zx_mem_core #(
	parameter int comp_factor = 4,
	parameter int comp_gain   = 2
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  zx_pkg::machine_t              machine,
	input  logic [zx_pkg::addr_w-1:0]     bus_addr,
	input  logic [zx_pkg::data_w-1:0]     bus_data,
	input  logic                          io_req,
	output logic                          io_ack,
	output logic [zx_pkg::ram_addr_w-1:0] ram_addr,
	output logic                          ram_we_ok,
	output logic [2:0]                    border,
	input  logic [zx_pkg::psg_w-1:0]      psg_l,
	input  logic [zx_pkg::psg_w-1:0]      psg_r,
	output logic [zx_pkg::audio_w-1:0]    audio_l,
	output logic [zx_pkg::audio_w-1:0]    audio_r
);
	import zx_pkg::*;

	logic              wr_stb;
	logic [addr_w-1:0] wr_addr;
	logic [data_w-1:0] wr_data;
	logic              ear;
	logic              mic;

	paging_if pg_bus ();

	// I/O write path
	io_port_unit u_io (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus_addr (bus_addr),
		.bus_data (bus_data),
		.io_req   (io_req),
		.io_ack   (io_ack),
		.wr_stb   (wr_stb),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	page_regs u_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.wr_stb  (wr_stb),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.pg      (pg_bus.src)
	);

	// Memory map follows the live CPU address
	ram_mapper u_map (
		.bus_addr  (bus_addr),
		.pg        (pg_bus.dst),
		.ram_addr  (ram_addr),
		.ram_we_ok (ram_we_ok)
	);

	audio_mixer #(
		.comp_factor (comp_factor),
		.comp_gain   (comp_gain)
	) u_mix (
		.clk_sys (clk_sys),
		.reset   (reset),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.ear     (ear),
		.mic     (mic),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

//--- testbench/tb_zx_mem_core.sv
// Self-checking bench for zx_mem_core with default mixer parameters; one I/O write at a time
`timescale 1ns/1ps

module tb_zx_mem_core;
	import zx_pkg::*;

	localparam int clk_period   = 100;
	localparam int drive_delay  = 10;
	// Tests need about 1500 cycles at most
	localparam int limit_cycles = 4000;
	localparam int factor       = 4;
	localparam int gain         = 2;
	localparam int knee         = (32767 * (factor - 1)) / (factor * gain - 1) + 1;
	// +3 special banks, three bits per slot, config 0 slot 0 lowest
	localparam logic [47:0] spec_tab = {12'o3674, 12'o3654, 12'o7654, 12'o3210};

	logic              clk_sys;
	logic              reset;
	machine_t          machine;
	logic [15:0]       bus_addr;
	logic [7:0]        bus_data;
	logic              io_req;
	logic              io_ack;
	logic [24:0]       ram_addr;
	logic              ram_we_ok;
	logic [2:0]        border;
	logic [11:0]       psg_l;
	logic [11:0]       psg_r;
	logic [15:0]       audio_l;
	logic [15:0]       audio_r;

	// Reference state
	machine_t          m_machine;
	logic [7:0]        m_7ffd;
	logic [7:0]        m_1ffd;
	logic [2:0]        m_ext;
	logic              m_eff7_b2;
	logic [2:0]        exp_border;
	logic              exp_ear;
	logic              exp_mic;
	logic [24:0]       exp_ram_addr;
	logic              exp_we_ok;
	logic [15:0]       exp_l1;
	logic [15:0]       exp_l2;
	logic [15:0]       exp_r1;
	logic [15:0]       exp_r2;
	int                exp_bank;
	int                exp_rom_page;

	string             test_name;
	int                test_errors  = 0;
	int                total_errors = 0;
	int                n_tests      = 0;
	int                n_failed     = 0;
	int                cycles       = 0;

	zx_mem_core DUT (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.machine   (machine),
		.bus_addr  (bus_addr),
		.bus_data  (bus_data),
		.io_req    (io_req),
		.io_ack    (io_ack),
		.ram_addr  (ram_addr),
		.ram_we_ok (ram_we_ok),
		.border    (border),
		.psg_l     (psg_l),
		.psg_r     (psg_r),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit_cycles) begin
			$display("Run stopped at %0d cycles, the tests did not finish", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Reference rules
	// ======================================================================

	function automatic logic [15:0] mix_ref(input logic [11:0] psg, input logic e, input logic m);
		int sum;
		int mag;
		int shaped;
		sum = int'(psg) * 16 + int'(e) * 4096 + int'(m) * 2048;
		sum = sum % 65536;
		if (sum >= 32768)
			sum = sum - 65536;
		mag = (sum < 0) ? -sum : sum;
		if (mag < knee)
			shaped = mag * gain;
		else
			shaped = knee * gain + (mag - knee) / factor;
		if (sum < 0)
			shaped = -shaped;
		return 16'(shaped);
	endfunction

	always_comb begin
		exp_we_ok    = 1'b1;
		exp_bank     = 0;
		exp_rom_page = 0;
		if (m_1ffd[0]) begin
			exp_bank = int'(spec_tab[{m_1ffd[2:1], bus_addr[15:14]} * 3 +: 3]);
		end else begin
			case (bus_addr[15:14])
				2'd0: exp_we_ok = 1'b0;
				2'd1: exp_bank = 5;
				2'd2: exp_bank = 2;
				default: exp_bank = int'(m_ext) * 8 + int'(m_7ffd[2:0]);
			endcase
		end
		if (m_machine == machine_plus3)
			exp_rom_page = 8 + 2 * int'(m_1ffd[2]) + int'(m_7ffd[4]);
		else if (m_machine == machine_zx48)
			exp_rom_page = 15;
		else
			exp_rom_page = 6 + int'(m_7ffd[4]);
		if (!exp_we_ok)
			exp_ram_addr = 25'((5 << 18) + exp_rom_page * 16384 + int'(bus_addr[13:0]));
		else
			exp_ram_addr = 25'(exp_bank * 16384 + int'(bus_addr[13:0]));
	end

	// Two-cycle audio reference
	always @(posedge clk_sys) begin
		if (reset) begin
			exp_l1 <= '0;
			exp_l2 <= '0;
			exp_r1 <= '0;
			exp_r2 <= '0;
		end else begin
			exp_l1 <= mix_ref(psg_l, exp_ear, exp_mic);
			exp_r1 <= mix_ref(psg_r, exp_ear, exp_mic);
			exp_l2 <= exp_l1;
			exp_r2 <= exp_r1;
		end
	end

	// Port writes as the CPU sees them, applied on the update edge
	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		logic lock;
		lock = (m_machine == machine_zx48) ||
			(m_7ffd[5] && (m_machine != machine_p1024 || m_eff7_b2));
		if (!a[0]) begin
			exp_border <= d[2:0];
			exp_ear    <= d[4];
			exp_mic    <= d[3];
		end
		if (!a[15] && !a[1] && (a[14] || m_machine != machine_plus3) && !lock) begin
			m_7ffd <= d;
			if (m_machine == machine_p1024 && !m_eff7_b2)
				m_ext <= {d[5], d[7], d[6]};
		end
		if (m_machine == machine_plus3 && !a[1] && a[12] && a[15:13] == 3'b000 && !lock)
			m_1ffd <= d;
		if (m_machine == machine_p1024 && a[15:13] == 3'b111 && !a[12] && !a[3])
			m_eff7_b2 <= d[2];
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic report_value(input string what, input logic [31:0] expv,
		input logic [31:0] actv);
		test_errors++;
		$display("** Error %s: %s expected %0h, actual %0h", test_name, what, expv, actv);
	endtask

	task automatic report_event(input string what);
		test_errors++;
		$display("Handshake failure in %s: %s", test_name, what);
	endtask

	a_ack_reset: assert property (@(posedge clk_sys) $fell(reset) |-> !io_ack)
		else report_event("io_ack was high right after reset");
	a_ack_rise: assert property (@(posedge clk_sys) disable iff (reset)
		(io_req && !io_ack) |=> io_ack)
		else report_event("io_ack did not rise after a new request");
	a_ack_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(io_req && io_ack) |=> io_ack)
		else report_event("io_ack dropped while io_req was held");
	a_ack_fall: assert property (@(posedge clk_sys) disable iff (reset)
		(!io_req && io_ack) |=> !io_ack)
		else report_event("io_ack did not fall after io_req dropped");
	a_ack_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(!io_req && !io_ack) |=> !io_ack)
		else report_event("io_ack rose without a request");
	a_border: assert property (@(posedge clk_sys) disable iff (reset) border == exp_border)
		else report_value("border", $sampled(exp_border), $sampled(border));
	a_ram_addr: assert property (@(posedge clk_sys) disable iff (reset)
		ram_addr == exp_ram_addr)
		else report_value("ram_addr", $sampled(exp_ram_addr), $sampled(ram_addr));
	a_we_ok: assert property (@(posedge clk_sys) disable iff (reset) ram_we_ok == exp_we_ok)
		else report_value("ram_we_ok", $sampled(exp_we_ok), $sampled(ram_we_ok));
	a_audio_l: assert property (@(posedge clk_sys) disable iff (reset) audio_l == exp_l2)
		else report_value("audio_l", $sampled(exp_l2), $sampled(audio_l));
	a_audio_r: assert property (@(posedge clk_sys) disable iff (reset) audio_r == exp_r2)
		else report_value("audio_r", $sampled(exp_r2), $sampled(audio_r));

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	task automatic apply_reset(input machine_t m);
		@(posedge clk_sys);
		#drive_delay;
		reset   = 1'b1;
		machine = m;
		io_req  = 1'b0;
		repeat (8) @(posedge clk_sys);
		#drive_delay;
		reset      = 1'b0;
		m_machine  = m;
		m_7ffd     = '0;
		m_1ffd     = '0;
		m_ext      = '0;
		m_eff7_b2  = 1'b0;
		exp_border = '0;
		exp_ear    = 1'b0;
		exp_mic    = 1'b0;
	endtask

	// Update lands one cycle after io_ack rises
	task automatic io_write(input logic [15:0] a, input logic [7:0] d, input int hold);
		@(posedge clk_sys);
		#drive_delay;
		bus_addr = a;
		bus_data = d;
		io_req   = 1'b1;
		do begin
			@(posedge clk_sys);
			#drive_delay;
		end while (!io_ack);
		@(posedge clk_sys);
		model_write(a, d);
		repeat (hold) @(posedge clk_sys);
		#drive_delay;
		io_req = 1'b0;
		do begin
			@(posedge clk_sys);
			#drive_delay;
		end while (io_ack);
	endtask

	task automatic sweep_slots(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			#drive_delay;
			bus_addr = {2'(i), 14'($urandom)};
		end
		@(posedge clk_sys);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		repeat (3) @(posedge clk_sys);
		#drive_delay;
		n_tests++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("test %-12s passed", test_name);
		end else begin
			n_failed++;
			$display("test %-12s failed, %0d errors", test_name, test_errors);
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		int i;
		void'($urandom(32'ha0d5_cfb0));
		reset    = 1'b1;
		machine  = machine_zx128;
		bus_addr = '0;
		bus_data = '0;
		io_req   = 1'b0;
		psg_l    = '0;
		psg_r    = '0;
		apply_reset(machine_zx128);

		start_test("handshake");
		io_write(port_fe, 8'h15, 0);
		io_write(port_fe, 8'h0a, 5);
		end_test();

		start_test("port_fe");
		repeat (40) io_write({15'($urandom), 1'b0}, 8'($urandom), 0);
		end_test();

		start_test("paging_128");
		apply_reset(machine_zx128);
		for (i = 0; i < 8; i++) begin
			io_write(port_7ffd, {2'($urandom), 1'b0, 1'($urandom), 1'($urandom), 3'(i)}, 0);
			sweep_slots(4);
		end
		io_write(port_7ffd, 8'h23, 0);
		repeat (4) io_write(port_7ffd, 8'($urandom), 0);
		sweep_slots(4);
		apply_reset(machine_zx48);
		io_write(port_7ffd, 8'h17, 0);
		sweep_slots(4);
		end_test();

		start_test("plus3");
		apply_reset(machine_plus3);
		for (i = 0; i < 4; i++) begin
			io_write(port_1ffd, {5'($urandom), 2'(i), 1'b1}, 0);
			sweep_slots(4);
		end
		for (i = 0; i < 4; i++) begin
			io_write(port_7ffd, {2'($urandom), 1'b0, 1'(i), 1'($urandom), 3'($urandom)}, 0);
			io_write(port_1ffd, {5'($urandom), 1'(i >> 1), 1'($urandom), 1'b0}, 0);
			sweep_slots(4);
		end
		end_test();

		start_test("pentagon");
		apply_reset(machine_p1024);
		repeat (8) begin
			io_write(port_7ffd, 8'($urandom), 0);
			sweep_slots(4);
		end
		// Extension frozen from here on
		io_write(port_eff7, 8'h04, 0);
		repeat (6) begin
			io_write(port_7ffd, 8'($urandom), 0);
			sweep_slots(4);
		end
		end_test();

		start_test("audio");
		for (i = 0; i < 8; i++) begin
			io_write(port_fe, 8'($urandom), 0);
			repeat (24) begin
				@(posedge clk_sys);
				#drive_delay;
				psg_l = 12'($urandom);
				psg_r = 12'($urandom);
			end
		end
		// Full-scale corners
		@(posedge clk_sys);
		#drive_delay;
		psg_l = 12'h800;
		psg_r = 12'h7ff;
		end_test();

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors);
		if (total_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
hdl/zx_pkg.sv
hdl/paging_if.sv
hdl/io_port_unit.sv
hdl/page_regs.sv
hdl/ram_mapper.sv
hdl/audio_mixer.sv
hdl/zx_mem_core.sv
testbench/tb_zx_mem_core.sv

//--- Makefile
# Verilator build and run for the zx_mem_core testbench

VERILATOR ?= verilator
TOP       ?= tb_zx_mem_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP OBJ_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
